/* common/alu_pkg.sv */
/*
  widths, types and encodings shared by the fixed-point ALU
  mode meaning depends on op; mode 3 behaves like mode 2 in both units
*/
package alu_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int OPERAND_W = 13;   // operand and result width
    localparam int FRAC_W    = 8;    // multiplier fraction, also multiply iterations
    localparam int QUOT_W    = 9;    // quotient width, also divide iterations

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [FRAC_W-1:0]    frac_t;
    typedef logic [QUOT_W-1:0]    quot_t;

    //////////////////////////////
    // operation select
    //////////////////////////////
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,              // idle, neither unit runs
        OP_MUL  = 2'd1,
        OP_DIV  = 2'd2
    } alu_op_t;

    typedef logic [1:0] alu_mode_t;

    // multiply modes
    localparam alu_mode_t MUL_PURE = 2'd0;   // floor(x*y/256)
    localparam alu_mode_t MUL_FRAC = 2'd1;   // x + floor(x*y/256)
    localparam alu_mode_t MUL_MAX  = 2'd2;   // bounded to 2x

    // divide modes, quotient is floor(x * 2^s / y)
    localparam alu_mode_t DIV_S8 = 2'd0;     // s = 8
    localparam alu_mode_t DIV_S7 = 2'd1;     // s = 7
    localparam alu_mode_t DIV_S6 = 2'd2;     // s = 6

    //////////////////////////////
    // unit state machines
    //////////////////////////////
    typedef enum logic [1:0] {
        M_LOAD,
        M_ITER,
        M_FINISH,
        M_DONE
    } mult_state_t;

    typedef enum logic [1:0] {
        D_LOAD,
        D_ITER,
        D_FINISH,
        D_DONE
    } div_state_t;

endpackage

/* hw/mult/shift_add_mult.sv */
/*
  serial shift-add multiplier, 10 cycles for modes 0/1 and 2 cycles for mode 2
  x_in, y_in and mode must stay steady while go is high; go low clears the FSM
*/
module shift_add_mult (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                go,
    input  alu_pkg::alu_mode_t  mode,
    input  alu_pkg::operand_t   x_in,
    input  alu_pkg::frac_t      y_in,
    output alu_pkg::operand_t   product,
    output logic                done
);
    import alu_pkg::*;

    localparam int ACC_W = OPERAND_W + FRAC_W;   // full x*y fits without loss
    localparam int CNT_W = $clog2(FRAC_W);

    mult_state_t        state;
    logic [CNT_W-1:0]   bit_cnt;                 // remaining add/shift steps
    logic [ACC_W-1:0]   acc;                     // high part sums, low part holds y bits
    logic [OPERAND_W:0] sum;                     // one extra bit for the carry
    logic               iter_mode;

    // modes 0 and 1 walk the fraction bits and the rest load the 2x bound
    assign iter_mode = (mode == MUL_PURE) || (mode == MUL_FRAC);

    // add x when the current lsb of y is set
    assign sum = {1'b0, acc[ACC_W-1:FRAC_W]} + (acc[0] ? {1'b0, x_in} : '0);

    assign product = acc[ACC_W-1:FRAC_W];       // floor(acc / 256)
    assign done    = (state == M_DONE);

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state   <= M_LOAD;
            bit_cnt <= '0;
        end else if (!go) begin                  // caller dropped go so start over
            state   <= M_LOAD;
            bit_cnt <= '0;
        end else begin
            case (state)
                M_LOAD: begin
                    bit_cnt <= CNT_W'(FRAC_W - 1);
                    state   <= iter_mode ? M_ITER : M_FINISH;
                end
                M_ITER: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin
                        state <= M_FINISH;       // last fraction bit consumed
                    end
                end
                M_FINISH: state <= M_DONE;
                default:  state <= M_DONE;       // hold done until go falls
            endcase
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (go) begin
            case (state)
                M_LOAD: begin
                    if (iter_mode) begin
                        acc <= {{OPERAND_W{1'b0}}, y_in};
                    end else begin
                        // 2x goes straight into the product field and its top bit drops
                        acc <= {x_in[OPERAND_W-2:0], 1'b0, {FRAC_W{1'b0}}};
                    end
                end
                M_ITER: begin
                    acc <= {sum, acc[FRAC_W-1:1]};   // add then shift right
                end
                M_FINISH: begin
                    if (mode == MUL_FRAC) begin
                        acc[ACC_W-1:FRAC_W] <= acc[ACC_W-1:FRAC_W] + x_in;  // the "one plus"
                    end
                end
                default: ;
            endcase
        end
    end

    // done rises only while go is still high
    a_done_needs_go: assert property (
        @(posedge CLK) disable iff (!RST_N)
        $rose(done) |-> go
    ) else $error("multiplier done rose without go");

endmodule

/* hw/div/restoring_div.sv */
/*
  serial restoring divider, 9-bit quotient in 11 cycles, 2 cycles when saturated
  saturates to 511 when (x >> (9-s)) >= y, which also covers y == 0
*/
module restoring_div (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                go,
    input  alu_pkg::alu_mode_t  mode,
    input  alu_pkg::operand_t   x_in,
    input  alu_pkg::operand_t   y_in,
    output alu_pkg::quot_t      quotient,
    output logic                done
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(QUOT_W);

    div_state_t         state;
    logic [CNT_W-1:0]   bit_cnt;                 // quotient bits still to produce
    operand_t           rem;                     // partial remainder, always < y
    quot_t              shq;                     // dividend low bits out, quotient bits in
    logic [3:0]         scale;                   // s from the mode
    operand_t           head;                    // x >> (9 - s), the dividend above the quotient
    logic               sat;
    logic [OPERAND_W:0] partial;                 // remainder with next dividend bit
    logic [OPERAND_W:0] diff;
    logic               fits;

    // scale select, mode 3 falls through to s = 6
    always_comb begin
        case (mode)
            DIV_S8:  scale = 4'd8;
            DIV_S7:  scale = 4'd7;
            default: scale = 4'd6;
        endcase
        head = x_in >> (QUOT_W - int'(scale));
    end

    assign sat = (head >= y_in);                 // quotient would not fit in 9 bits

    // one restoring step
    assign partial = {rem, shq[QUOT_W-1]};
    assign diff    = partial - {1'b0, y_in};
    assign fits    = (partial >= {1'b0, y_in});

    assign quotient = shq;
    assign done     = (state == D_DONE);

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state   <= D_LOAD;
            bit_cnt <= '0;
        end else if (!go) begin
            state   <= D_LOAD;
            bit_cnt <= '0;
        end else begin
            case (state)
                D_LOAD: begin
                    bit_cnt <= CNT_W'(QUOT_W - 1);
                    state   <= sat ? D_FINISH : D_ITER;   // saturation skips the loop
                end
                D_ITER: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin
                        state <= D_FINISH;
                    end
                end
                D_FINISH: state <= D_DONE;
                default:  state <= D_DONE;
            endcase
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (go) begin
            case (state)
                D_LOAD: begin
                    if (sat) begin
                        rem <= '0;
                        shq <= '1;                            // 511
                    end else begin
                        // x * 2^s split into remainder head and 9 low bits
                        {rem, shq} <= {{QUOT_W{1'b0}}, x_in} << scale;
                    end
                end
                D_ITER: begin
                    rem <= fits ? diff[OPERAND_W-1:0] : partial[OPERAND_W-1:0];
                    shq <= {shq[QUOT_W-2:0], fits};            // quotient bit enters at lsb
                end
                default: ;
            endcase
        end
    end

    // the loop needs y nonzero and steady for every quotient bit
    a_no_zero_divisor: assert property (
        @(posedge CLK) disable iff (!RST_N)
        (state == D_ITER) |-> ((y_in != '0) && $stable(y_in))
    ) else $error("divider iterating with zero or changing divisor");

endmodule

/* hw/alu_dispatch.sv */
/*
  starts one unit from alu_start and op, registers the combined result
  adds one cycle ahead of the unit and one after; alu_start low clears everything
*/
module alu_dispatch (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                alu_start,
    input  alu_pkg::alu_op_t    op,
    output logic                mul_go,
    output logic                div_go,
    input  alu_pkg::operand_t   product,
    input  logic                mul_done,
    input  alu_pkg::quot_t      quotient,
    input  logic                div_done,
    output alu_pkg::operand_t   result,
    output logic                alu_done
);
    import alu_pkg::*;

    //////////////////////////////
    // unit start levels
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            mul_go <= 1'b0;
            div_go <= 1'b0;
        end else begin
            mul_go <= alu_start && (op == OP_MUL);
            div_go <= alu_start && (op == OP_DIV);   // OP_NONE starts nothing
        end
    end

    //////////////////////////////
    // result capture
    //////////////////////////////
    // done is only trusted together with its own go, so a unit still
    // clearing from the last request is ignored
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            result   <= '0;
            alu_done <= 1'b0;
        end else if (!alu_start) begin
            result   <= '0;                          // caller released so clear the output
            alu_done <= 1'b0;
        end else if (mul_go && mul_done) begin
            result   <= product;
            alu_done <= 1'b1;
        end else if (div_go && div_done) begin
            result   <= {{(OPERAND_W - QUOT_W){1'b0}}, quotient};  // zero-extend
            alu_done <= 1'b1;
        end
    end

    // at most one unit reports done
    a_one_done: assert property (
        @(posedge CLK) disable iff (!RST_N)
        !(mul_done && div_done)
    ) else $error("both units report done");

    // done rises while the caller still holds start
    a_done_in_request: assert property (
        @(posedge CLK) disable iff (!RST_N)
        $rose(alu_done) |-> alu_start
    ) else $error("alu_done without a pending start");

endmodule

/* hw/fixed_alu.sv */
/*
  fixed-point ALU top: serial multiply and divide behind one start/done handshake
  hold alu_start and inputs until alu_done, then drop alu_start to clear
*/
module fixed_alu (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                alu_start,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_mode_t  mode,
    input  alu_pkg::operand_t   x_in,
    input  alu_pkg::operand_t   y_in,
    output alu_pkg::operand_t   result,
    output logic                alu_done
);
    import alu_pkg::*;

    logic     mul_go;
    logic     div_go;
    logic     mul_done;
    logic     div_done;
    operand_t product;
    quot_t    quotient;

    //////////////////////////////
    // dispatch
    //////////////////////////////
    alu_dispatch alu_dispatch_i (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .alu_start (alu_start),
        .op        (op),
        .mul_go    (mul_go),
        .div_go    (div_go),
        .product   (product),
        .mul_done  (mul_done),
        .quotient  (quotient),
        .div_done  (div_done),
        .result    (result),
        .alu_done  (alu_done)
    );

    //////////////////////////////
    // units
    //////////////////////////////
    shift_add_mult shift_add_mult_i (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .go      (mul_go),
        .mode    (mode),
        .x_in    (x_in),
        .y_in    (y_in[FRAC_W-1:0]),   // fraction is the low byte
        .product (product),
        .done    (mul_done)
    );

    restoring_div restoring_div_i (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .go       (div_go),
        .mode     (mode),
        .x_in     (x_in),
        .y_in     (y_in),
        .quotient (quotient),
        .done     (div_done)
    );

endmodule

/* bench/tb_clock_gen.sv */
/*
  testbench clock and reset, 10 ns period
  reset held low for 5 rising edges, released 1 ns after the fifth
*/
module tb_clock_gen (
    output logic CLK,
    output logic RST_N
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;                   // half period
    end

    initial begin
        RST_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 RST_N = 1'b1;                         // same input delay as the stimulus
    end

endmodule

/* bench/fixed_alu_tb.sv */
/*
  random multiply and divide requests through the start/done handshake
  expected values come from ref_result, compared when alu_done rises
*/
module fixed_alu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int DONE_TIMEOUT  = 40;           // cycles from start to alu_done
    localparam int CLEAR_TIMEOUT = 4;            // cycles from start low to alu_done low
    localparam int RESET_TIMEOUT = 20;

    logic      CLK;
    logic      RST_N;
    logic      alu_start;
    alu_op_t   op;
    alu_mode_t mode;
    operand_t  x_in;
    operand_t  y_in;
    operand_t  result;
    logic      alu_done;

    logic [31:0] lfsr_state = 32'hacd8426d;
    operand_t    exp_q[$];                       // one entry per pending request
    logic        done_q = 1'b0;
    logic        hung = 1'b0;                    // set once a handshake wait runs out
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen tb_clock_gen_i (.CLK(CLK), .RST_N(RST_N));

    fixed_alu fixed_alu_i (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .alu_start (alu_start),
        .op        (op),
        .mode      (mode),
        .x_in      (x_in),
        .y_in      (y_in),
        .result    (result),
        .alu_done  (alu_done)
    );

    //////////////////////////////
    // random source
    //////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic int div_scale(input alu_mode_t m);
        return (m == DIV_S8) ? 8 : (m == DIV_S7) ? 7 : 6;   // mode 3 like mode 2
    endfunction

    // quotient would overflow 9 bits
    function automatic bit div_saturates(input operand_t x, input operand_t y,
                                         input alu_mode_t m);
        return (int'(x) >> (9 - div_scale(m))) >= int'(y);
    endfunction

    function automatic operand_t ref_result(input alu_op_t o, input alu_mode_t m,
                                            input operand_t x, input operand_t y);
        int unsigned frac_prod;
        if (o == OP_MUL) begin
            frac_prod = (int'(x) * int'(y[7:0])) >> 8;        // floor(x*y/256)
            if (m == MUL_PURE) return operand_t'(frac_prod);
            if (m == MUL_FRAC) return operand_t'(int'(x) + frac_prod);
            return operand_t'(int'(x) * 2);
        end
        if (div_saturates(x, y, m)) return operand_t'(511);
        return operand_t'((int'(x) << div_scale(m)) / int'(y));
    endfunction

    //////////////////////////////
    // compare on the rising edge of alu_done
    //////////////////////////////
    always @(negedge CLK) begin
        operand_t expected;
        if (RST_N && alu_done && !done_q) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("alu_done rose at %0t ns with no request pending", $time);
            end else begin
                expected = exp_q.pop_front();
                checks++;
                assert (result == expected) else begin
                    errors++;
                    $display(
                        "Error at %0t ns: result = %0h, expected %0h (%s mode %0d x %0h y %0h)",
                        $time, result, expected, op.name(), mode, x_in, y_in);
                end
            end
        end
        done_q <= alu_done;
    end

    task automatic finish_sim();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // raise start and wait for done, then drop start and wait for the clear
    task automatic run_op(input alu_op_t o, input alu_mode_t m,
                          input operand_t x, input operand_t y);
        int cycles;
        if (hung) begin
            return;                              // nothing more runs once a wait ran out
        end
        @(posedge CLK);
        #1;
        op        = o;
        mode      = m;
        x_in      = x;
        y_in      = y;
        alu_start = 1'b1;
        exp_q.push_back(ref_result(o, m, x, y));
        cycles = 0;
        while (!alu_done && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!alu_done) begin
            errors++;
            hung = 1'b1;
            $display("timeout, alu_done did not rise within %0d cycles", DONE_TIMEOUT);
        end else begin
            @(posedge CLK);
            #1 alu_start = 1'b0;
            cycles = 0;
            while (alu_done && cycles < CLEAR_TIMEOUT) begin
                @(negedge CLK);
                cycles++;
            end
            if (alu_done) begin
                errors++;
                hung = 1'b1;
                $display("timeout, alu_done stayed high after start was dropped");
            end else begin
                assert (result == '0) else begin    // clear passed through dispatch
                    errors++;
                    $display("Error at %0t ns: result = 0x%0h, expected 0x0 after clear",
                             $time, result);
                end
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        int       cycles;
        operand_t x;
        operand_t y;
        alu_start = 1'b0;
        op        = OP_NONE;
        mode      = '0;
        x_in      = '0;
        y_in      = '0;
        cycles    = 0;
        while (!RST_N && cycles < RESET_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!RST_N) begin
            errors++;
            $display("timeout, reset was never released");
            finish_sim();
        end else begin
            @(negedge CLK);
            assert (!alu_done) else begin
                errors++;
                $display("Error at %0t ns: alu_done = %0b, expected 0 after reset",
                         $time, alu_done);
            end
            assert (result == '0) else begin
                errors++;
                $display("Error at %0t ns: result = 0x%0h, expected 0x0 after reset",
                         $time, result);
            end
            // y gets 13 bits so the ignored top bits of the multiplier are exercised
            for (int i = 0; i < 200; i++) begin
                x = operand_t'(rand_bits(13));
                y = operand_t'(rand_bits(13));
                run_op(OP_MUL, MUL_PURE, x, y);
            end
            for (int i = 0; i < 60; i++) begin
                x = operand_t'(rand_bits(13));
                y = operand_t'(rand_bits(13));
                run_op(OP_MUL, MUL_FRAC, x, y);
            end
            for (int i = 0; i < 60; i++) begin
                x = operand_t'(rand_bits(13));
                y = operand_t'(rand_bits(13));
                run_op(OP_MUL, alu_mode_t'(2 + rand_bits(1)), x, y);
            end
            // divide in every scale select including mode 3
            for (int m = 0; m < 4; m++) begin
                for (int i = 0; i < 60; i++) begin
                    y = operand_t'(rand_bits(13));
                    if (y == '0) y = 13'd1;
                    x = operand_t'(rand_bits(13));
                    while (div_saturates(x, y, alu_mode_t'(m))) x = x >> 1;  // keep it in range
                    run_op(OP_DIV, alu_mode_t'(m), x, y);
                end
                for (int i = 0; i < 20; i++) begin
                    // head of x is at least 512 and the divisor below 256
                    x = operand_t'(rand_bits(13)) | 13'h1000;
                    y = operand_t'(rand_bits(8));
                    run_op(OP_DIV, alu_mode_t'(m), x, y);
                end
                x = operand_t'(rand_bits(13));
                run_op(OP_DIV, alu_mode_t'(m), x, '0);   // zero divisor
                run_op(OP_DIV, alu_mode_t'(m), '0, '0);
            end
            finish_sim();
        end
    end

endmodule

/* verilog.f */
common/alu_pkg.sv
hw/mult/shift_add_mult.sv
hw/div/restoring_div.sv
hw/alu_dispatch.sv
hw/fixed_alu.sv
bench/tb_clock_gen.sv
bench/fixed_alu_tb.sv

/* Makefile */
# Verilator build and run for the fixed-point ALU testbench
# override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= fixed_alu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
